// ==== dv/mipsPipe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsPipe_checker (
    input logic           clk,
    input logic           rstN,
    input logic           run,
    input isaPkg::wordT   pc,
    input logic           regWriteEn,
    input isaPkg::regIdxT regWriteAddr
);

    int failCount = 0;  // Read by the testbench

    // Nothing reaches write-back straight out of reset
    quietAfterReset: assert property (@(posedge clk) !rstN |=> !regWriteEn)
        else begin
            $error("regWriteEn high in the cycle after reset");
            failCount++;
        end

    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        regWriteEn |-> (regWriteAddr != '0))
        else begin
            $error("register write to $zero reached the write port");
            failCount++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            failCount++;
        end

    // Fetch is frozen until run goes high
    pcHeldWhileIdle: assert property (@(posedge clk) disable iff (!rstN)
        !run |=> $stable(pc))
        else begin
            $error("pc moved while run was low");
            failCount++;
        end

endmodule

bind mipsPipeTop mipsPipe_checker portChecker (
    .clk          (clk),
    .rstN         (rstN),
    .run          (run),
    .pc           (pc),
    .regWriteEn   (regWriteEn),
    .regWriteAddr (regWriteAddr)
);

`default_nettype wire

// ==== dv/mipsPipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_cfg.svh"

module mipsPipe_tb;

    localparam int ProgLen       = 60;
    localparam int LoadWords     = ProgLen + 2;  // Two nops behind the final self-jump
    localparam int ResetCycles   = 4;
    localparam int QuietCycles   = 20;
    localparam int Period        = 100;
    localparam int TimeoutCycles = ResetCycles + LoadWords + 20 * ProgLen + QuietCycles + 20;

    logic                                clk;
    logic                                rstN;
    logic                                run;
    logic                                imemWe;
    logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imemAddr;
    isaPkg::wordT                        imemData;
    isaPkg::wordT                        pc;
    logic                                regWriteEn;
    isaPkg::regIdxT                      regWriteAddr;
    isaPkg::wordT                        regWriteData;
    isaPkg::wordT                        v0;
    isaPkg::wordT                        v1;

    integer         seed = 32'h8905_b070;
    isaPkg::wordT   progMem [LoadWords];
    isaPkg::wordT   modelRegs [32];
    isaPkg::wordT   modelMem [`MIPS_DMEM_WORDS];
    int             modelPc;         // Word index the model runs next
    int             storedWords[$];  // Data words written by an executed sw
    isaPkg::regIdxT expAddr[$];
    isaPkg::wordT   expData[$];
    int             writesSeen = 0;

    tbClock #(.period(Period)) clockGen (.clk(clk));

    mipsPipeTop mipsPipeTop_inst (
        .clk          (clk),
        .rstN         (rstN),
        .run          (run),
        .imemWe       (imemWe),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .pc           (pc),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .v0           (v0),
        .v1           (v1)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abortRun();
        $display("sim failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic reportMismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        abortRun();
    endtask

    task automatic reportProblem(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        abortRun();
    endtask

    task automatic checkWrite(input isaPkg::regIdxT gotAddr, input isaPkg::wordT gotData,
                              input isaPkg::regIdxT wantAddr, input isaPkg::wordT wantData);
        if (gotAddr !== wantAddr || gotData !== wantData) begin
            reportMismatch($sformatf("write %0d went to $%0d = %h, expected $%0d = %h",
                                     writesSeen, gotAddr, gotData, wantAddr, wantData));
        end
    endtask

    task automatic checkWord(input isaPkg::wordT got, input isaPkg::wordT want,
                             input string what);
        if (got !== want) begin
            reportMismatch($sformatf("%s is %h, expected %h", what, got, want));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding and random picks
    ////////////////////////////////////////////////////////////////////////////

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic isaPkg::regIdxT pickSource();
        int r;
        r = randBelow(16);
        if (r == 15) begin
            return isaPkg::regRa;  // Read back a link value now and then
        end
        return isaPkg::regIdxT'(r % 8);
    endfunction

    function automatic isaPkg::regIdxT pickDest();
        return isaPkg::regIdxT'(randBelow(8));  // $zero included on purpose
    endfunction

    function automatic isaPkg::wordT byteAddr(int idx);
        return `MIPS_RESET_PC + isaPkg::wordT'(idx) * 4;
    endfunction

    function automatic isaPkg::wordT encodeR(isaPkg::functT fn, isaPkg::regIdxT rs,
                                             isaPkg::regIdxT rt, isaPkg::regIdxT rd,
                                             logic [4:0] shamt);
        return {isaPkg::OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic isaPkg::wordT encodeI(isaPkg::opcodeT op, isaPkg::regIdxT rs,
                                             isaPkg::regIdxT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isaPkg::wordT encodeJ(isaPkg::opcodeT op, int targetIdx);
        isaPkg::wordT target;
        target = byteAddr(targetIdx);
        return {op, target[27:2]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Instruction-set model, one instruction per call
    ////////////////////////////////////////////////////////////////////////////

    task automatic executeModel(input isaPkg::wordT instr);
        isaPkg::wordT   a;
        isaPkg::wordT   b;
        isaPkg::wordT   imm;
        isaPkg::wordT   result;
        isaPkg::wordT   target;
        isaPkg::regIdxT dest;
        logic           writes;
        int             nextPc;
        int             word;
        a      = modelRegs[instr[25:21]];
        b      = modelRegs[instr[20:16]];
        imm    = {{16{instr[15]}}, instr[15:0]};
        dest   = instr[20:16];
        writes = 1'b0;
        result = '0;
        nextPc = modelPc + 1;
        word   = int'((a + imm) >> 2);
        case (instr[31:26])
            isaPkg::OP_RTYPE: begin
                writes = 1'b1;
                dest   = instr[15:11];
                case (instr[5:0])
                    isaPkg::FN_ADDU: result = a + b;
                    isaPkg::FN_SUBU: result = a - b;
                    isaPkg::FN_AND:  result = a & b;
                    isaPkg::FN_OR:   result = a | b;
                    isaPkg::FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    isaPkg::FN_SLL:  result = b << instr[10:6];
                    default:         writes = 1'b0;
                endcase
            end
            isaPkg::OP_ADDIU: begin
                writes = 1'b1;
                result = a + imm;
            end
            isaPkg::OP_LW: begin
                writes = 1'b1;
                result = modelMem[word];
            end
            isaPkg::OP_SW: begin
                modelMem[word] = b;
                storedWords.push_back(word);
            end
            isaPkg::OP_BEQ: begin
                if (a == b) begin
                    nextPc = modelPc + 1 + int'($signed(imm));
                end
            end
            isaPkg::OP_J, isaPkg::OP_JAL: begin
                target = byteAddr(modelPc + 1);
                target = {target[31:28], instr[25:0], 2'b00};
                nextPc = int'((target - `MIPS_RESET_PC) >> 2);
                if (instr[31:26] == isaPkg::OP_JAL) begin
                    writes = 1'b1;
                    dest   = isaPkg::regRa;
                    result = byteAddr(modelPc + 1);  // Return address
                end
            end
            default: ;
        endcase
        if (writes && dest != '0) begin
            modelRegs[dest] = result;
            expAddr.push_back(dest);
            expData.push_back(result);
        end
        modelPc = nextPc;
    endtask

    // Control flow only goes forward, so the model runs alongside generation
    // and the generator knows which stores really happened
    task automatic buildProgram();
        int           kind;
        int           span;
        int           word;
        isaPkg::wordT instr;
        modelPc = 0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int w = 0; w < `MIPS_DMEM_WORDS; w++) begin
            modelMem[w] = '0;
        end
        for (int i = 0; i < ProgLen - 1; i++) begin
            kind = randBelow(16);
            if ((kind == 11 || kind == 12) && storedWords.size() == 0) begin
                kind = 0;  // No load before a store
            end
            case (kind)
                0, 1, 2: instr = encodeI(isaPkg::OP_ADDIU, pickSource(), pickDest(),
                                         16'(randBelow(65536)));
                3: instr = encodeR(isaPkg::FN_ADDU, pickSource(), pickSource(), pickDest(), 0);
                4: instr = encodeR(isaPkg::FN_SUBU, pickSource(), pickSource(), pickDest(), 0);
                5: instr = encodeR(isaPkg::FN_AND, pickSource(), pickSource(), pickDest(), 0);
                6: instr = encodeR(isaPkg::FN_OR, pickSource(), pickSource(), pickDest(), 0);
                7: instr = encodeR(isaPkg::FN_SLT, pickSource(), pickSource(), pickDest(), 0);
                8: instr = encodeR(isaPkg::FN_SLL, 5'd0, pickSource(), pickDest(),
                                   5'(randBelow(32)));
                9, 10: begin
                    word  = randBelow(`MIPS_DMEM_WORDS);
                    instr = encodeI(isaPkg::OP_SW, 5'd0, pickSource(), 16'(word * 4));
                end
                11, 12: begin
                    word  = storedWords[randBelow(storedWords.size())];
                    instr = encodeI(isaPkg::OP_LW, 5'd0, pickDest(), 16'(word * 4));
                end
                13: begin
                    span  = (ProgLen - 2 - i > 3) ? 3 : ProgLen - 2 - i;
                    instr = encodeI(isaPkg::OP_BEQ, pickSource(), pickSource(),
                                    16'(randBelow(span + 1)));
                end
                default: begin
                    span  = (ProgLen - 1 - i > 4) ? 4 : ProgLen - 1 - i;
                    instr = encodeJ((kind == 14) ? isaPkg::OP_J : isaPkg::OP_JAL,
                                    i + 1 + randBelow(span));
                end
            endcase
            progMem[i] = instr;
            if (modelPc == i) begin
                executeModel(instr);
            end
        end
        progMem[ProgLen - 1] = encodeJ(isaPkg::OP_J, ProgLen - 1);  // Park here
        progMem[ProgLen]     = '0;
        progMem[ProgLen + 1] = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadProgram();
        for (int i = 0; i < LoadWords; i++) begin
            @(posedge clk);
            #1;
            imemWe   = 1'b1;
            imemAddr = i[$clog2(`MIPS_IMEM_WORDS)-1:0];
            imemData = progMem[i];
        end
        @(posedge clk);
        #1;
        imemWe = 1'b0;
    endtask

    // pc walks the self-jump and its two flushed successors
    task automatic checkSelfJumpLoop();
        isaPkg::wordT loopPc;
        isaPkg::wordT expPc;
        loopPc = byteAddr(ProgLen - 1);
        expPc  = loopPc;
        if (pc == loopPc + 4 || pc == loopPc + 8) begin
            expPc = pc;
        end
        for (int k = 0; k < 6; k++) begin
            checkWord(pc, expPc, "pc in final self-jump loop");
            expPc = (expPc == loopPc + 8) ? loopPc : expPc + 4;
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (rstN) begin
            if (mipsPipeTop_inst.portChecker.failCount != 0) begin
                reportProblem("an assertion in the port checker failed");
            end
            if (!run) begin
                checkWord(pc, `MIPS_RESET_PC, "pc before run");
                if (regWriteEn) begin
                    reportProblem("a register write appeared before run was raised");
                end
            end else if (regWriteEn) begin
                if (expAddr.size() == 0) begin
                    reportProblem("a register write appeared after the last expected one");
                end else begin
                    checkWrite(regWriteAddr, regWriteData, expAddr.pop_front(),
                               expData.pop_front());
                    writesSeen++;
                end
            end
        end
    end

    initial begin : mainFlow
        rstN     = 1'b0;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        buildProgram();
        $display("Program of %0d instructions, %0d register writes expected",
                 ProgLen, expAddr.size());
        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        loadProgram();
        @(posedge clk);
        #1;
        run = 1'b1;
        while (expAddr.size() != 0) begin
            @(negedge clk);
        end
        repeat (QuietCycles) @(negedge clk);  // Stray writes get caught meanwhile
        checkWord(v0, modelRegs[isaPkg::regV0], "v0");
        checkWord(v1, modelRegs[isaPkg::regV1], "v1");
        checkSelfJumpLoop();
        if (mipsPipeTop_inst.portChecker.failCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            reportProblem("an assertion in the port checker failed");
        end
    end

    initial begin : watchdog
        #(TimeoutCycles * Period);
        reportProblem($sformatf("the program did not finish within %0d clock cycles",
                                TimeoutCycles));
    end

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int period = 100  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== include/mipsPipe_cfg.svh ====
`ifndef MIPSPIPE_CFG_SVH
`define MIPSPIPE_CFG_SVH

// Instruction memory depth in 32-bit words
`define MIPS_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 64

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== mipsPipe.f ====
+incdir+include
src/isaPkg.sv
src/pipePkg.sv
src/pipeStage.sv
src/hazardUnit.sv
src/decodeUnit.sv
src/registerFile.sv
src/aluUnit.sv
src/wordMemory.sv
src/mipsPipeTop.sv
dv/tbClock.sv
dv/mipsPipe_checker.sv
dv/mipsPipe_tb.sv

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  pipePkg::aluOpT op,
    input  isaPkg::wordT   a,
    input  isaPkg::wordT   b,
    input  logic [4:0]     shamt,
    output isaPkg::wordT   result,
    output logic           zero
);

    always_comb begin
        case (op)
            pipePkg::ALU_ADD: result = a + b;
            pipePkg::ALU_SUB: result = a - b;
            pipePkg::ALU_AND: result = a & b;
            pipePkg::ALU_OR:  result = a | b;
            pipePkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            pipePkg::ALU_SLL: result = b << shamt;  // sll shifts rt
            default:          result = '0;
        endcase
    end

    assign zero = (result == '0); // beq taken when a - b is zero

endmodule

`default_nettype wire

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  isaPkg::wordT   instr,
    output pipePkg::ctrlT  ctrl,
    output isaPkg::wordT   imm,
    output isaPkg::regIdxT dest,
    output logic           usesRt
);

    isaPkg::opcodeT opcode;
    isaPkg::functT  funct;

    assign opcode = isaPkg::opcodeT'(instr[31:26]);
    assign funct  = isaPkg::functT'(instr[5:0]);
    assign imm    = {{16{instr[15]}}, instr[15:0]}; // Sign extend

    always_comb begin
        ctrl   = '0;                 // Unknown encodings stay a no-op
        dest   = instr[20:16];       // rt unless told otherwise
        usesRt = 1'b0;
        case (opcode)
            isaPkg::OP_RTYPE: begin
                dest          = instr[15:11];
                usesRt        = 1'b1;
                ctrl.valid    = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    isaPkg::FN_ADDU: ctrl.aluOp = pipePkg::ALU_ADD;
                    isaPkg::FN_SUBU: ctrl.aluOp = pipePkg::ALU_SUB;
                    isaPkg::FN_AND:  ctrl.aluOp = pipePkg::ALU_AND;
                    isaPkg::FN_OR:   ctrl.aluOp = pipePkg::ALU_OR;
                    isaPkg::FN_SLT:  ctrl.aluOp = pipePkg::ALU_SLT;
                    isaPkg::FN_SLL: begin
                        ctrl.aluOp    = pipePkg::ALU_SLL;
                        ctrl.useShamt = 1'b1;
                    end
                    default: begin
                        ctrl   = '0;
                        usesRt = 1'b0;
                    end
                endcase
            end
            isaPkg::OP_ADDIU: begin
                ctrl.valid    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = pipePkg::ALU_ADD;
            end
            isaPkg::OP_LW: begin
                ctrl.valid    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = pipePkg::ALU_ADD;
            end
            isaPkg::OP_SW: begin
                usesRt        = 1'b1;    // Store data
                ctrl.valid    = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = pipePkg::ALU_ADD;
            end
            isaPkg::OP_BEQ: begin
                usesRt        = 1'b1;
                ctrl.valid    = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = pipePkg::ALU_SUB; // Zero flag means equal
            end
            isaPkg::OP_J: begin
                ctrl.valid    = 1'b1;
                ctrl.jump     = 1'b1;
            end
            isaPkg::OP_JAL: begin
                dest          = isaPkg::regRa;
                ctrl.valid    = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  isaPkg::regIdxT rs,
    input  isaPkg::regIdxT rt,
    input  logic           usesRt,
    input  pipePkg::ctrlT  exCtrl,
    input  pipePkg::ctrlT  memCtrl,
    input  isaPkg::regIdxT exDest,
    input  isaPkg::regIdxT memDest,
    output logic           stall
);

    logic exPending;  // EX stage will write exDest
    logic memPending; // MEM stage will write memDest
    logic rsHazard;
    logic rtHazard;

    assign exPending  = exCtrl.valid && exCtrl.regWrite && (exDest != '0);
    assign memPending = memCtrl.valid && memCtrl.regWrite && (memDest != '0);

    // No forwarding, so a load-use is just a longer RAW stall
    // WB stage needs no check, the register file writes through
    assign rsHazard = (rs != '0) &&
                      ((exPending && (rs == exDest)) || (memPending && (rs == memDest)));
    assign rtHazard = usesRt && (rt != '0) &&
                      ((exPending && (rt == exDest)) || (memPending && (rt == memDest)));

    assign stall = rsHazard || rtHazard;

endmodule

`default_nettype wire

// ==== src/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;   // Data and instruction word
    typedef logic [4:0]  regIdxT; // Register number

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeT;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functT;

    localparam regIdxT regRa = 5'd31; // Link register for jal
    localparam regIdxT regV0 = 5'd2;
    localparam regIdxT regV1 = 5'd3;

endpackage

`default_nettype wire

// ==== src/mipsPipeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_cfg.svh"

module mipsPipeTop (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 run,       // Low holds fetch at reset PC
    input  logic                                 imemWe,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imemAddr,  // Word address
    input  isaPkg::wordT                         imemData,
    output isaPkg::wordT                         pc,
    output logic                                 regWriteEn,
    output isaPkg::regIdxT                       regWriteAddr,
    output isaPkg::wordT                         regWriteData,
    output isaPkg::wordT                         v0,
    output isaPkg::wordT                         v1
);

    localparam int ImemAw = $clog2(`MIPS_IMEM_WORDS);
    localparam int DmemAw = $clog2(`MIPS_DMEM_WORDS);

    pipePkg::ifIdT  ifIdD, ifIdQ;
    pipePkg::idExT  idExD, idExQ;
    pipePkg::exMemT exMemD, exMemQ;
    pipePkg::memWbT memWbD, memWbQ;

    logic stall;
    logic flush;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    isaPkg::wordT pcPlus4;
    isaPkg::wordT nextPc;
    isaPkg::wordT instrFetched;

    assign pcPlus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `MIPS_RESET_PC;
        end else if (flush || (run && !stall)) begin
            pc <= nextPc;
        end
    end

    // Load port writes, fetch reads
    wordMemory #(.depth(`MIPS_IMEM_WORDS)) imem (
        .clk   (clk),
        .we    (imemWe),
        .wAddr (imemAddr),
        .wData (imemData),
        .rAddr (pc[ImemAw+1:2]),
        .rData (instrFetched)
    );

    assign ifIdD = '{pcPlus4: pcPlus4, instr: instrFetched, valid: run};

    pipeStage #(.payloadT(pipePkg::ifIdT)) ifIdReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .d     (ifIdD),
        .q     (ifIdQ)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    pipePkg::ctrlT  decCtrl;
    pipePkg::ctrlT  idCtrl;
    isaPkg::wordT   decImm;
    isaPkg::regIdxT decDest;
    logic           decUsesRt;
    isaPkg::regIdxT rsIdx;
    isaPkg::regIdxT rtIdx;
    isaPkg::wordT   rsData;
    isaPkg::wordT   rtData;

    assign rsIdx = ifIdQ.instr[25:21];
    assign rtIdx = ifIdQ.instr[20:16];

    decodeUnit decoder (
        .instr  (ifIdQ.instr),
        .ctrl   (decCtrl),
        .imm    (decImm),
        .dest   (decDest),
        .usesRt (decUsesRt)
    );

    assign idCtrl = ifIdQ.valid ? decCtrl : '0;  // Empty slot stays a bubble

    registerFile regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rs     (rsIdx),
        .rt     (rtIdx),
        .rsData (rsData),
        .rtData (rtData),
        .we     (regWriteEn),
        .wAddr  (regWriteAddr),
        .wData  (regWriteData),
        .v0     (v0),
        .v1     (v1)
    );

    hazardUnit hazard (
        .rs      (rsIdx),
        .rt      (rtIdx),
        .usesRt  (decUsesRt),
        .exCtrl  (idExQ.ctrl),
        .memCtrl (exMemQ.ctrl),
        .exDest  (idExQ.dest),
        .memDest (exMemQ.dest),
        .stall   (stall)
    );

    assign idExD = '{ctrl: idCtrl, pcPlus4: ifIdQ.pcPlus4, rsData: rsData,
                     rtData: rtData, imm: decImm, shamt: ifIdQ.instr[10:6],
                     dest: decDest,
                     jumpTarget: {ifIdQ.pcPlus4[31:28], ifIdQ.instr[25:0], 2'b00}};

    // A stalled decode sends a bubble forward
    pipeStage #(.payloadT(pipePkg::idExT)) idExReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (1'b0),
        .flush (flush || stall),
        .d     (idExD),
        .q     (idExQ)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute, branches and jumps resolve here
    ////////////////////////////////////////////////////////////////////////////

    isaPkg::wordT aluB;
    isaPkg::wordT aluResult;
    isaPkg::wordT branchTarget;
    logic [4:0]   aluShamt;
    logic         aluZero;

    assign aluB     = idExQ.ctrl.useImm ? idExQ.imm : idExQ.rtData;
    assign aluShamt = idExQ.ctrl.useShamt ? idExQ.shamt : 5'd0;

    aluUnit alu (
        .op     (idExQ.ctrl.aluOp),
        .a      (idExQ.rsData),
        .b      (aluB),
        .shamt  (aluShamt),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign branchTarget = idExQ.pcPlus4 + {idExQ.imm[29:0], 2'b00};

    assign flush = idExQ.ctrl.valid &&
                   (idExQ.ctrl.jump || (idExQ.ctrl.branch && aluZero));

    assign nextPc = !flush ? pcPlus4 :
                    idExQ.ctrl.jump ? idExQ.jumpTarget : branchTarget;

    assign exMemD = '{ctrl: idExQ.ctrl, result: aluResult, storeData: idExQ.rtData,
                      dest: idExQ.dest, pcPlus4: idExQ.pcPlus4};

    pipeStage #(.payloadT(pipePkg::exMemT)) exMemReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (1'b0),
        .flush (1'b0),
        .d     (exMemD),
        .q     (exMemQ)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and write-back
    ////////////////////////////////////////////////////////////////////////////

    isaPkg::wordT loadData;

    // ALU result is the byte address, drop the low two bits
    wordMemory #(.depth(`MIPS_DMEM_WORDS)) dmem (
        .clk   (clk),
        .we    (exMemQ.ctrl.memWrite),
        .wAddr (exMemQ.result[DmemAw+1:2]),
        .wData (exMemQ.storeData),
        .rAddr (exMemQ.result[DmemAw+1:2]),
        .rData (loadData)
    );

    assign memWbD = '{ctrl: exMemQ.ctrl, result: exMemQ.result, loadData: loadData,
                      pcPlus4: exMemQ.pcPlus4, dest: exMemQ.dest};

    pipeStage #(.payloadT(pipePkg::memWbT)) memWbReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (1'b0),
        .flush (1'b0),
        .d     (memWbD),
        .q     (memWbQ)
    );

    // Writes to $zero never leave the pipeline
    assign regWriteEn   = memWbQ.ctrl.valid && memWbQ.ctrl.regWrite &&
                          (memWbQ.dest != '0);
    assign regWriteAddr = memWbQ.dest;
    assign regWriteData = memWbQ.ctrl.memRead ? memWbQ.loadData :
                          memWbQ.ctrl.link    ? memWbQ.pcPlus4  : memWbQ.result;

endmodule

`default_nettype wire

// ==== src/pipePkg.sv ====
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5
    } aluOpT;

    // Control bundle, all zero is a bubble
    typedef struct packed {
        logic  valid;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;   // beq
        logic  jump;     // j and jal
        logic  link;     // jal writes pc+4
        logic  useImm;   // ALU b from immediate
        logic  useShamt; // Shift amount from instruction
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        isaPkg::wordT pcPlus4;
        isaPkg::wordT instr;
        logic         valid;
    } ifIdT;

    typedef struct packed {
        ctrlT           ctrl;
        isaPkg::wordT   pcPlus4;
        isaPkg::wordT   rsData;
        isaPkg::wordT   rtData;
        isaPkg::wordT   imm;
        logic [4:0]     shamt;
        isaPkg::regIdxT dest;
        isaPkg::wordT   jumpTarget;
    } idExT;

    typedef struct packed {
        ctrlT           ctrl;
        isaPkg::wordT   result;
        isaPkg::wordT   storeData;
        isaPkg::regIdxT dest;
        isaPkg::wordT   pcPlus4; // Carried on for jal write-back
    } exMemT;

    typedef struct packed {
        ctrlT           ctrl;
        isaPkg::wordT   result;
        isaPkg::wordT   loadData;
        isaPkg::wordT   pcPlus4;
        isaPkg::regIdxT dest;
    } memWbT;

endpackage

`default_nettype wire

// ==== src/pipeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

// One pipeline register, payload chosen per instance
module pipeStage #(
    parameter type payloadT = pipePkg::ifIdT
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // All-zero payload has valid and write enables low, so it acts as a bubble
    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;              // Flush wins over stall
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rs,
    input  isaPkg::regIdxT rt,
    output isaPkg::wordT   rsData,
    output isaPkg::wordT   rtData,
    input  logic           we,
    input  isaPkg::regIdxT wAddr,
    input  isaPkg::wordT   wData,
    output isaPkg::wordT   v0,
    output isaPkg::wordT   v1
);

    isaPkg::wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wAddr != '0)) begin
            regs[wAddr] <= wData;
        end
    end

    // Write-through so decode sees a same-cycle write-back
    assign rsData = (rs == '0) ? '0 : (we && (wAddr == rs)) ? wData : regs[rs];
    assign rtData = (rt == '0) ? '0 : (we && (wAddr == rt)) ? wData : regs[rt];

    assign v0 = regs[isaPkg::regV0];
    assign v1 = regs[isaPkg::regV1];

endmodule

`default_nettype wire

// ==== src/wordMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

// Word-addressed RAM, async read and clocked write
module wordMemory #(
    parameter int depth = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] wAddr,
    input  logic [31:0]              wData,
    input  logic [$clog2(depth)-1:0] rAddr,
    output logic [31:0]              rData
);

    logic [31:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    assign rData = mem[rAddr]; // Same-cycle read

endmodule

`default_nettype wire
